// ==== files.f ====
wbuf_cfg_pkg.sv
wbuf_types_pkg.sv
wbuf_rr_arb.sv
wbuf_store.sv
wbuf_tx_split.sv
wbuf_tx_track.sv
wbuf_top.sv
tb_wbuf.sv

// ==== Bender.yml ====
package:
  name: wbuf

sources:
  - wbuf_cfg_pkg.sv
  - wbuf_types_pkg.sv
  - wbuf_rr_arb.sv
  - wbuf_store.sv
  - wbuf_tx_split.sv
  - wbuf_tx_track.sv
  - wbuf_top.sv
  - target: simulation
    files:
      - tb_wbuf.sv

// ==== tb_wbuf.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the write buffer, random stores over six words
// memory model acks with stalls and returns IDs in random order
// byte model counts a byte as held from its store until its response,
// a lower bound of what the buffer really holds
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_wbuf;

  localparam int unsigned NumWords     = 6;
  localparam int unsigned NumImgBytes  = NumWords * wbuf_cfg_pkg::NumBytes;
  localparam logic [31:0] BaseAddr     = 32'h0000_1000;
  localparam int unsigned NumStores    = 400;
  localparam int unsigned GntTimeout   = 200;
  localparam int unsigned DrainTimeout = 1000;

  logic                       clk;
  logic                       rst_n;
  wbuf_types_pkg::core_wreq_t core_req;
  logic                       core_gnt;
  logic                       mem_req;
  wbuf_types_pkg::mem_wreq_t  mem_wreq;
  logic                       mem_ack;
  wbuf_types_pkg::mem_rtrn_t  mem_rtrn;
  logic                       empty;

  logic [15:0] lfsr_q;
  int unsigned errors;
  int unsigned timeouts;
  logic        store_started;
  // negedge samples taken by the stimulus process
  logic        gnt_seen;
  logic        empty_seen;

  // golden image from stores, memory image from accepted transfers
  logic [7:0]  golden  [NumImgBytes];
  logic [7:0]  mem_img [NumImgBytes];
  // written but not sent yet
  logic        dirty_m [NumImgBytes];
  // written and not yet answered by memory
  logic        live    [NumImgBytes];
  int unsigned wr_seq  [NumImgBytes];

  // transfers in flight by ID, with the write count each byte carried
  logic        tx_vld  [wbuf_cfg_pkg::MaxTx];
  int unsigned tx_word [wbuf_cfg_pkg::MaxTx];
  logic [3:0]  tx_be   [wbuf_cfg_pkg::MaxTx];
  int unsigned tx_seq  [wbuf_cfg_pkg::MaxTx][wbuf_cfg_pkg::NumBytes];
  int unsigned pend_q  [$];

  always #5 clk = ~clk;

  wbuf_top uut (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .core_req_i (core_req),
    .core_gnt_o (core_gnt),
    .mem_req_o  (mem_req),
    .mem_wreq_o (mem_wreq),
    .mem_ack_i  (mem_ack),
    .mem_rtrn_i (mem_rtrn),
    .empty_o    (empty)
  );

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // galois lfsr, one step per bit taken, first bit ends up as msb
  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] val;
    logic        out;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      out    = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (out) begin
        lfsr_q = lfsr_q ^ 16'hB400;
      end
      val = {val[30:0], out};
    end
    return val;
  endfunction

  function automatic int unsigned word_of(input logic [31:0] addr);
    return (addr - BaseAddr) >> 2;
  endfunction

  // word holds at least one byte the buffer cannot have dropped
  function automatic logic is_held(input int unsigned w);
    return live[4*w] | live[4*w+1] | live[4*w+2] | live[4*w+3];
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp)
    else begin
      errors++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic must_hold(input logic cond, input string what);
    assert (cond)
    else begin
      errors++;
      $display("error at %0t: %s", $time, what);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // monitor, runs at negedge where all DUT outputs are settled
  ////////////////////////////////////////////////////////////////////////////

  // grant must follow the model occupancy
  task automatic judge_grant();
    int unsigned w;
    int unsigned others;
    w      = word_of(core_req.addr);
    others = 0;
    for (int unsigned v = 0; v < NumWords; v++) begin
      if (v != w && is_held(v)) begin
        others++;
      end
    end
    if (is_held(w)) begin
      compare_value("core_gnt_o", core_gnt, 1'b1);
    end else if (others >= wbuf_cfg_pkg::WbufDepth) begin
      compare_value("core_gnt_o", core_gnt, 1'b0);
    end
  endtask

  task automatic inspect_transfer();
    int unsigned w;
    int unsigned id;
    int unsigned idx;
    logic [3:0]  mask;
    logic [3:0]  sent_be;
    logic [1:0]  exp_off;
    logic [1:0]  exp_size;
    logic [31:0] exp_data;
    w  = word_of(mem_wreq.addr);
    id = mem_wreq.id;
    must_hold(w < NumWords, "transfer address outside the stored words");
    if (w < NumWords) begin
      for (int b = 0; b < 4; b++) begin
        mask[b] = dirty_m[4*w + b];
      end
      must_hold(mask != '0, "transfer for a word with no dirty byte");
      // lowest dirty byte, then the widest aligned size from there
      exp_off = '0;
      for (int b = 3; b >= 0; b--) begin
        if (mask[b]) begin
          exp_off = b[1:0];
        end
      end
      if (exp_off == 2'd0 && mask == 4'hF) begin
        exp_size = 2'd2;
      end else if (!exp_off[0] && mask[exp_off + 2'd1]) begin
        exp_size = 2'd1;
      end else begin
        exp_size = 2'd0;
      end
      idx = 4*w + exp_off;
      case (exp_size)
        2'd2:    exp_data = {golden[idx+3], golden[idx+2], golden[idx+1], golden[idx]};
        2'd1:    exp_data = {2{golden[idx+1], golden[idx]}};
        default: exp_data = {4{golden[idx]}};
      endcase
      compare_value("mem_wreq_o.addr", mem_wreq.addr, BaseAddr + 4*w + exp_off);
      compare_value("mem_wreq_o.size", mem_wreq.size, exp_size);
      compare_value("mem_wreq_o.wdata", mem_wreq.wdata, exp_data);
      // bytes that really went out, from the DUT's own address and size
      case (mem_wreq.size)
        2'd0:    sent_be = 4'b0001 << mem_wreq.addr[1:0];
        2'd1:    sent_be = 4'b0011 << mem_wreq.addr[1:0];
        default: sent_be = 4'b1111;
      endcase
      must_hold(!tx_vld[id], "transfer ID already in flight");
      for (int k = 0; k < wbuf_cfg_pkg::MaxTx; k++) begin
        if (tx_vld[k] && tx_word[k] == w) begin
          must_hold((tx_be[k] & sent_be) == '0, "byte sent while still in flight");
        end
      end
      tx_vld[id]  = 1'b1;
      tx_word[id] = w;
      tx_be[id]   = sent_be;
      for (int b = 0; b < 4; b++) begin
        if (sent_be[b]) begin
          tx_seq[id][b]    = wr_seq[4*w + b];
          dirty_m[4*w + b] = 1'b0;
          // replicated data puts every byte on its own lane too
          mem_img[4*w + b] = mem_wreq.wdata[8*b +: 8];
        end
      end
      pend_q.push_back(id);
    end
  endtask

  task automatic record_store();
    int unsigned w;
    int unsigned idx;
    w = word_of(core_req.addr);
    for (int b = 0; b < 4; b++) begin
      if (core_req.be[b]) begin
        idx          = 4*w + b;
        golden[idx]  = core_req.wdata[8*b +: 8];
        dirty_m[idx] = 1'b1;
        live[idx]    = 1'b1;
        wr_seq[idx]++;
      end
    end
  endtask

  always @(negedge clk) begin : p_monitor
    if (rst_n) begin
      // quiet until the first store shows up
      if (!store_started) begin
        compare_value("core_gnt_o", core_gnt, 1'b0);
        compare_value("mem_req_o", mem_req, 1'b0);
        compare_value("empty_o", empty, 1'b1);
      end
      if (core_req.req) begin
        judge_grant();
      end
      // transfer first, a store in the same cycle rewrites after it
      if (mem_req && mem_ack) begin
        inspect_transfer();
      end
      if (core_req.req && core_gnt) begin
        record_store();
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus and memory responder, one process so the lfsr order is fixed
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_memory();
    int unsigned pick;
    int unsigned id;
    mem_ack  = (take_bits(2) != 32'd0);
    mem_rtrn = '0;
    if (pend_q.size() > 0 && take_bits(1) == 32'd1) begin
      // any pending ID may come back, so order is random
      pick = take_bits(1) % pend_q.size();
      id   = pend_q[pick];
      pend_q.delete(pick);
      mem_rtrn.valid = 1'b1;
      mem_rtrn.id    = id[wbuf_cfg_pkg::TxIdWidth-1:0];
      // a byte rewritten after it was sent stays held
      for (int b = 0; b < 4; b++) begin
        if (tx_be[id][b] && tx_seq[id][b] == wr_seq[4*tx_word[id] + b]) begin
          live[4*tx_word[id] + b] = 1'b0;
        end
      end
      tx_vld[id] = 1'b0;
    end
  endtask

  // sample at negedge, drive 1 ns after the next rising edge
  task automatic next_cycle();
    @(negedge clk);
    gnt_seen   = core_req.req && core_gnt;
    empty_seen = empty;
    @(posedge clk);
    #1;
    drive_memory();
  endtask

  task automatic issue_store();
    int unsigned waited;
    int unsigned w;
    logic [31:0] bits;
    w              = take_bits(3) % NumWords;
    store_started  = 1'b1;
    core_req.addr  = BaseAddr + 4*w;
    bits           = take_bits(4);
    core_req.be    = bits[3:0];
    core_req.wdata = take_bits(32);
    core_req.req   = 1'b1;
    waited         = 0;
    gnt_seen       = 1'b0;
    // request stays up until granted
    while (!gnt_seen && waited < GntTimeout) begin
      next_cycle();
      waited++;
    end
    core_req.req = 1'b0;
    if (!gnt_seen) begin
      timeouts++;
      $display("timeout at %0t: store to %h was never granted", $time, core_req.addr);
    end
  endtask

  initial begin : p_main
    int unsigned waited;
    clk           = 1'b0;
    rst_n         = 1'b0;
    core_req      = '0;
    mem_ack       = 1'b0;
    mem_rtrn      = '0;
    lfsr_q        = 16'd36;
    errors        = 0;
    timeouts      = 0;
    store_started = 1'b0;
    gnt_seen      = 1'b0;
    empty_seen    = 1'b0;
    // both images start from the same address pattern
    for (int i = 0; i < NumImgBytes; i++) begin
      golden[i]  = 8'(i) ^ 8'h5A;
      mem_img[i] = 8'(i) ^ 8'h5A;
      dirty_m[i] = 1'b0;
      live[i]    = 1'b0;
      wr_seq[i]  = 0;
    end
    for (int k = 0; k < wbuf_cfg_pkg::MaxTx; k++) begin
      tx_vld[k] = 1'b0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (4) next_cycle();

    for (int n = 0; n < NumStores && timeouts == 0; n++) begin
      issue_store();
      if (take_bits(2) == 32'd0) begin
        next_cycle();
      end
    end

    // drain, then compare the two images byte by byte
    waited     = 0;
    empty_seen = 1'b0;
    while (!empty_seen && waited < DrainTimeout) begin
      next_cycle();
      waited++;
    end
    if (!empty_seen) begin
      timeouts++;
      $display("timeout at %0t: buffer did not drain", $time);
    end else begin
      for (int i = 0; i < NumImgBytes; i++) begin
        compare_value($sformatf("mem_img[%0d]", i), mem_img[i], golden[i]);
      end
    end

    $display("closing report: %0d check errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== wbuf_top.sv ====
////////////////////////////////////////////////////////////////////////////
// coalescing write buffer between a store port and a memory port
// a transfer is taken when mem_req_o and mem_ack_i are both high
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module wbuf_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  wbuf_types_pkg::core_wreq_t  core_req_i,
  output logic                        core_gnt_o,
  output logic                        mem_req_o,
  output wbuf_types_pkg::mem_wreq_t   mem_wreq_o,
  input  logic                        mem_ack_i,
  input  wbuf_types_pkg::mem_rtrn_t   mem_rtrn_i,
  output logic                        empty_o
);

  wbuf_types_pkg::wbuf_entry_t [wbuf_cfg_pkg::WbufDepth-1:0] entries;
  logic [wbuf_cfg_pkg::WbufDepth-1:0][wbuf_cfg_pkg::NumBytes-1:0] sendable;
  logic [wbuf_cfg_pkg::WbufDepth-1:0] dirty_req;
  wbuf_types_pkg::wbuf_entry_t        dirty_entry;
  logic [wbuf_cfg_pkg::PtrWidth-1:0]  dirty_ptr;
  logic                               dirty_vld;
  logic [wbuf_cfg_pkg::MaxTx-1:0]     tx_free;
  logic [wbuf_cfg_pkg::TxIdWidth-1:0] tx_id;
  logic                               id_vld;
  wbuf_types_pkg::mem_wreq_t          split_wreq;
  logic [wbuf_cfg_pkg::NumBytes-1:0]  tx_be;
  logic                               accept;
  logic                               evict;
  logic [wbuf_cfg_pkg::PtrWidth-1:0]  evict_ptr;
  logic [wbuf_cfg_pkg::NumBytes-1:0]  evict_be;

  for (genvar k = 0; k < wbuf_cfg_pkg::WbufDepth; k++) begin : gen_dirty
    assign dirty_req[k] = |sendable[k];
  end

  // a word to send and a free ID
  assign mem_req_o  = dirty_vld && id_vld;
  assign accept     = mem_req_o && mem_ack_i;
  assign mem_wreq_o = '{addr:  split_wreq.addr,
                        size:  split_wreq.size,
                        wdata: split_wreq.wdata,
                        id:    tx_id};

  wbuf_store u_store (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .core_req_i  (core_req_i),
    .send_en_i   (accept),
    .send_ptr_i  (dirty_ptr),
    .send_be_i   (tx_be),
    .evict_i     (evict),
    .evict_ptr_i (evict_ptr),
    .evict_be_i  (evict_be),
    .core_gnt_o  (core_gnt_o),
    .entries_o   (entries),
    .sendable_o  (sendable),
    .empty_o     (empty_o)
  );

  // next word with sendable bytes
  wbuf_rr_arb #(
    .NumIn     (wbuf_cfg_pkg::WbufDepth),
    .payload_t (wbuf_types_pkg::wbuf_entry_t)
  ) u_dirty_arb (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (dirty_req),
    .data_i  (entries),
    .gnt_i   (accept),
    .valid_o (dirty_vld),
    .data_o  (dirty_entry),
    .idx_o   (dirty_ptr)
  );

  // next free transaction ID, no payload
  wbuf_rr_arb #(
    .NumIn     (wbuf_cfg_pkg::MaxTx),
    .payload_t (logic)
  ) u_id_arb (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (tx_free),
    .data_i  ('0),
    .gnt_i   (accept),
    .valid_o (id_vld),
    .data_o  (),
    .idx_o   (tx_id)
  );

  wbuf_tx_split u_split (
    .entry_i (dirty_entry),
    .bmask_i (sendable[dirty_ptr]),
    .wreq_o  (split_wreq),
    .be_o    (tx_be)
  );

  wbuf_tx_track u_track (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .send_en_i   (accept),
    .send_id_i   (tx_id),
    .send_ptr_i  (dirty_ptr),
    .send_be_i   (tx_be),
    .rtrn_i      (mem_rtrn_i),
    .free_o      (tx_free),
    .evict_o     (evict),
    .evict_ptr_o (evict_ptr),
    .evict_be_o  (evict_be)
  );

endmodule

`default_nettype wire

// ==== wbuf_tx_track.sv ====
////////////////////////////////////////////////////////////////////////////
// transaction slot table, return-ID queue and eviction control
// each in-flight ID must return exactly once, in any order
// the queue does not fall through, eviction starts a cycle after the push
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module wbuf_tx_track (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                send_en_i,
  input  logic [wbuf_cfg_pkg::TxIdWidth-1:0]  send_id_i,
  input  logic [wbuf_cfg_pkg::PtrWidth-1:0]   send_ptr_i,
  input  logic [wbuf_cfg_pkg::NumBytes-1:0]   send_be_i,
  input  wbuf_types_pkg::mem_rtrn_t           rtrn_i,
  output logic [wbuf_cfg_pkg::MaxTx-1:0]      free_o,
  output logic                                evict_o,
  output logic [wbuf_cfg_pkg::PtrWidth-1:0]   evict_ptr_o,
  output logic [wbuf_cfg_pkg::NumBytes-1:0]   evict_be_o
);

  wbuf_types_pkg::tx_stat_t [wbuf_cfg_pkg::MaxTx-1:0] tx_d, tx_q;

  ////////////////////////////////////////////////////////////////////////////
  // return-ID queue
  ////////////////////////////////////////////////////////////////////////////

  logic [wbuf_cfg_pkg::TxIdWidth-1:0] rq_mem_q [wbuf_cfg_pkg::MaxTx];
  logic [wbuf_cfg_pkg::TxIdWidth-1:0] rq_wr_q, rq_rd_q;
  logic [wbuf_cfg_pkg::TxIdWidth:0]   rq_cnt_q;
  logic [wbuf_cfg_pkg::TxIdWidth-1:0] rtrn_id;

  // one eviction per cycle while IDs are queued
  assign evict_o = (rq_cnt_q != '0);
  assign rtrn_id = rq_mem_q[rq_rd_q];

  always_ff @(posedge clk_i) begin : p_rq_mem
    if (rtrn_i.valid) begin
      rq_mem_q[rq_wr_q] <= rtrn_i.id;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rq_ptr
    if (!rst_ni) begin
      rq_wr_q  <= '0;
      rq_rd_q  <= '0;
      rq_cnt_q <= '0;
    end else begin
      if (rtrn_i.valid) begin
        rq_wr_q <= rq_wr_q + 1'b1;
      end
      if (evict_o) begin
        rq_rd_q <= rq_rd_q + 1'b1;
      end
      rq_cnt_q <= rq_cnt_q + rtrn_i.valid - evict_o;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // slot table
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : p_slots
    tx_d = tx_q;
    if (evict_o) begin
      tx_d[rtrn_id].vld = 1'b0;
    end
    if (send_en_i) begin
      tx_d[send_id_i].vld = 1'b1;
      tx_d[send_id_i].ptr = send_ptr_i;
      tx_d[send_id_i].be  = send_be_i;
    end
  end

  for (genvar k = 0; k < wbuf_cfg_pkg::MaxTx; k++) begin : gen_free
    assign free_o[k] = !tx_q[k].vld;
  end

  assign evict_ptr_o = tx_q[rtrn_id].ptr;
  assign evict_be_o  = tx_q[rtrn_id].be;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      tx_q <= '0;
    end else begin
      tx_q <= tx_d;
    end
  end

  // responses only for transfers that are out
  a_rtrn_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rtrn_i.valid |-> tx_q[rtrn_i.id].vld)
    else $error("response for idle slot %0d", rtrn_i.id);

  // the ID arbiter must not hand out the slot being released
  a_no_reuse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (evict_o && send_en_i) |-> (send_id_i != rtrn_id))
    else $error("slot %0d allocated while being freed", send_id_i);

endmodule

`default_nettype wire

// ==== wbuf_tx_split.sv ====
////////////////////////////////////////////////////////////////////////////
// splits a sendable byte mask into one naturally aligned transfer
// bytes not covered stay dirty and leave in a later transfer
// the id field of wreq_o is left zero
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module wbuf_tx_split (
  input  wbuf_types_pkg::wbuf_entry_t        entry_i,
  input  logic [wbuf_cfg_pkg::NumBytes-1:0]  bmask_i,
  output wbuf_types_pkg::mem_wreq_t          wreq_o,
  output logic [wbuf_cfg_pkg::NumBytes-1:0]  be_o
);

  logic [wbuf_cfg_pkg::OffWidth-1:0]  off;
  logic [wbuf_cfg_pkg::SizeWidth-1:0] size;
  logic [wbuf_cfg_pkg::DataWidth-1:0] wdata;

  // offset of the lowest set byte
  always_comb begin : p_off
    off = '0;
    for (int b = wbuf_cfg_pkg::NumBytes - 1; b >= 0; b--) begin
      if (bmask_i[b]) begin
        off = b[wbuf_cfg_pkg::OffWidth-1:0];
      end
    end
  end

  // largest aligned size starting at off
  always_comb begin : p_size
    size       = wbuf_cfg_pkg::SizeByte;
    be_o       = '0;
    be_o[off]  = 1'b1;
    wdata      = {wbuf_cfg_pkg::NumBytes{entry_i.data[8*off +: 8]}};
    if (off == '0 && &bmask_i) begin
      size  = wbuf_cfg_pkg::SizeWord;
      be_o  = '1;
      wdata = entry_i.data;
    end else if (!off[0] && bmask_i[off + 1'b1]) begin
      // halfword on an even offset, replicated twice
      size               = wbuf_cfg_pkg::SizeHalf;
      be_o[off + 1'b1]   = 1'b1;
      wdata              = {(wbuf_cfg_pkg::NumBytes / 2){entry_i.data[8*off +: 16]}};
    end
  end

  assign wreq_o.addr  = {entry_i.wtag, off};
  assign wreq_o.size  = size;
  assign wreq_o.wdata = wdata;
  assign wreq_o.id    = '0;

endmodule

`default_nettype wire

// ==== wbuf_store.sv ====
////////////////////////////////////////////////////////////////////////////
// buffer entries with coalescing, byte-state updates and store grant
// byte states valid/dirty/txblock: 000 free, 110 dirty, 101 in flight,
// 111 rewritten while in flight and sent again after the response
// a word with any byte in flight sends nothing until that response
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module wbuf_store (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  wbuf_types_pkg::core_wreq_t          core_req_i,
  input  logic                                send_en_i,
  input  logic [wbuf_cfg_pkg::PtrWidth-1:0]   send_ptr_i,
  input  logic [wbuf_cfg_pkg::NumBytes-1:0]   send_be_i,
  input  logic                                evict_i,
  input  logic [wbuf_cfg_pkg::PtrWidth-1:0]   evict_ptr_i,
  input  logic [wbuf_cfg_pkg::NumBytes-1:0]   evict_be_i,
  output logic                                core_gnt_o,
  output wbuf_types_pkg::wbuf_entry_t [wbuf_cfg_pkg::WbufDepth-1:0] entries_o,
  output logic [wbuf_cfg_pkg::WbufDepth-1:0][wbuf_cfg_pkg::NumBytes-1:0] sendable_o,
  output logic                                empty_o
);

  wbuf_types_pkg::wbuf_entry_t [wbuf_cfg_pkg::WbufDepth-1:0] entries_d, entries_q;
  logic [wbuf_cfg_pkg::WbufDepth-1:0] hit_oh;
  logic [wbuf_cfg_pkg::WbufDepth-1:0] free;
  logic [wbuf_cfg_pkg::PtrWidth-1:0]  hit_ptr, free_ptr, wr_ptr;
  logic [wbuf_cfg_pkg::WtagWidth-1:0] req_wtag;

  assign req_wtag = core_req_i.addr[wbuf_cfg_pkg::AddrWidth-1:wbuf_cfg_pkg::OffWidth];

  for (genvar k = 0; k < wbuf_cfg_pkg::WbufDepth; k++) begin : gen_flags
    // an entry is free once no byte is valid
    assign free[k]       = ~|entries_q[k].valid;
    assign hit_oh[k]     = !free[k] && (entries_q[k].wtag == req_wtag);
    // no resend while a transfer of this word is outstanding
    assign sendable_o[k] = (|entries_q[k].txblock) ? '0
                         : entries_q[k].valid & entries_q[k].dirty;
  end

  // lowest hit and lowest free entry
  always_comb begin : p_search
    hit_ptr  = '0;
    free_ptr = '0;
    for (int k = wbuf_cfg_pkg::WbufDepth - 1; k >= 0; k--) begin
      if (hit_oh[k]) begin
        hit_ptr = k[wbuf_cfg_pkg::PtrWidth-1:0];
      end
      if (free[k]) begin
        free_ptr = k[wbuf_cfg_pkg::PtrWidth-1:0];
      end
    end
  end

  assign wr_ptr     = (|hit_oh) ? hit_ptr : free_ptr;
  assign core_gnt_o = core_req_i.req && ((|hit_oh) || (|free));
  assign empty_o    = &free;
  assign entries_o  = entries_q;

  always_comb begin : p_update
    entries_d = entries_q;

    // response came back, release the bytes unless rewritten meanwhile
    if (evict_i) begin
      for (int b = 0; b < wbuf_cfg_pkg::NumBytes; b++) begin
        if (evict_be_i[b]) begin
          entries_d[evict_ptr_i].txblock[b] = 1'b0;
          if (!entries_q[evict_ptr_i].dirty[b]) begin
            entries_d[evict_ptr_i].valid[b] = 1'b0;
          end
        end
      end
    end

    // accepted transfer, bytes go from dirty to in flight
    if (send_en_i) begin
      for (int b = 0; b < wbuf_cfg_pkg::NumBytes; b++) begin
        if (send_be_i[b]) begin
          entries_d[send_ptr_i].dirty[b]   = 1'b0;
          entries_d[send_ptr_i].txblock[b] = 1'b1;
        end
      end
    end

    // granted store merges last, so it wins over both above
    if (core_gnt_o) begin
      entries_d[wr_ptr].wtag = req_wtag;
      for (int b = 0; b < wbuf_cfg_pkg::NumBytes; b++) begin
        if (core_req_i.be[b]) begin
          entries_d[wr_ptr].valid[b]      = 1'b1;
          entries_d[wr_ptr].dirty[b]      = 1'b1;
          entries_d[wr_ptr].data[8*b +: 8] = core_req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      entries_q <= '0;
    end else begin
      entries_q <= entries_d;
    end
  end

  // a word lives in one entry only
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_req_i.req |-> $onehot0(hit_oh))
    else $error("store address hits more than one entry");

  for (genvar k = 0; k < wbuf_cfg_pkg::WbufDepth; k++) begin : gen_chk_entry
    for (genvar b = 0; b < wbuf_cfg_pkg::NumBytes; b++) begin : gen_chk_byte
      a_byte_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
        {entries_q[k].valid[b], entries_q[k].dirty[b], entries_q[k].txblock[b]}
          inside {3'b000, 3'b110, 3'b101, 3'b111})
        else $error("illegal byte state in entry %0d byte %0d", k, b);
    end
  end

endmodule

`default_nettype wire

// ==== wbuf_rr_arb.sv ====
////////////////////////////////////////////////////////////////////////////
// locking round-robin arbiter with a generic payload
// a pending ungranted choice stays locked, so the chosen request
// must not drop before gnt_i
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module wbuf_rr_arb #(
  parameter int unsigned NumIn = 4,
  parameter type payload_t = logic,
  localparam int unsigned IdxWidth = (NumIn > 1) ? $clog2(NumIn) : 1
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic     [NumIn-1:0]      req_i,
  input  payload_t [NumIn-1:0]      data_i,
  input  logic                      gnt_i,
  output logic                      valid_o,
  output payload_t                  data_o,
  output logic     [IdxWidth-1:0]   idx_o
);

  // last granted index sets the search start
  logic [IdxWidth-1:0] rr_q;
  logic                lock_q;
  logic [IdxWidth-1:0] lock_idx_q;
  logic [IdxWidth-1:0] sel_idx;

  // first request after the last grant, wrapping around
  always_comb begin : p_search
    int unsigned j;
    int unsigned base;
    logic        found;
    sel_idx = '0;
    found   = 1'b0;
    base    = rr_q;
    for (int unsigned i = 1; i <= NumIn; i++) begin
      j = (base + i) % NumIn;
      if (!found && req_i[j]) begin
        found   = 1'b1;
        sel_idx = j[IdxWidth-1:0];
      end
    end
  end

  assign valid_o = |req_i;
  assign idx_o   = lock_q ? lock_idx_q : sel_idx;
  assign data_o  = data_i[idx_o];

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      // hold the choice while the consumer stalls
      lock_q     <= valid_o && !gnt_i;
      lock_idx_q <= idx_o;
      if (valid_o && gnt_i) begin
        rr_q <= idx_o;
      end
    end
  end

  // a locked request has to wait for its grant
  a_lock_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lock_q |-> req_i[lock_idx_q])
    else $error("locked request dropped before grant");

endmodule

`default_nettype wire

// ==== wbuf_types_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// port and state structs of the write buffer
// the memory request address is aligned to its size by the sender
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package wbuf_types_pkg;

  // store request from the core, held until granted
  typedef struct packed {
    logic                                 req;
    logic [wbuf_cfg_pkg::AddrWidth-1:0]   addr;
    logic [wbuf_cfg_pkg::DataWidth-1:0]   wdata;
    logic [wbuf_cfg_pkg::NumBytes-1:0]    be;
  } core_wreq_t;

  // write request to memory, short data replicated over the bus
  typedef struct packed {
    logic [wbuf_cfg_pkg::AddrWidth-1:0]   addr;
    logic [wbuf_cfg_pkg::SizeWidth-1:0]   size;
    logic [wbuf_cfg_pkg::DataWidth-1:0]   wdata;
    logic [wbuf_cfg_pkg::TxIdWidth-1:0]   id;
  } mem_wreq_t;

  // write response, one cycle per transfer
  typedef struct packed {
    logic                                 valid;
    logic [wbuf_cfg_pkg::TxIdWidth-1:0]   id;
  } mem_rtrn_t;

  // one buffered word with per-byte valid/dirty/txblock
  typedef struct packed {
    logic [wbuf_cfg_pkg::WtagWidth-1:0]   wtag;
    logic [wbuf_cfg_pkg::DataWidth-1:0]   data;
    logic [wbuf_cfg_pkg::NumBytes-1:0]    valid;
    logic [wbuf_cfg_pkg::NumBytes-1:0]    dirty;
    logic [wbuf_cfg_pkg::NumBytes-1:0]    txblock;
  } wbuf_entry_t;

  // one in-flight transaction slot
  typedef struct packed {
    logic                                 vld;
    logic [wbuf_cfg_pkg::PtrWidth-1:0]    ptr;
    logic [wbuf_cfg_pkg::NumBytes-1:0]    be;
  } tx_stat_t;

endpackage

`default_nettype wire

// ==== wbuf_cfg_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// sizes and widths of the coalescing write buffer
// 32-bit data path only, one word per entry
// MaxTx must be a power of two, the return-ID queue relies on pointer wrap
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package wbuf_cfg_pkg;

  // address and data path
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned NumBytes  = DataWidth / 8;
  localparam int unsigned OffWidth  = $clog2(NumBytes);
  // word address, i.e. the byte address without its offset
  localparam int unsigned WtagWidth = AddrWidth - OffWidth;

  // buffer entries
  localparam int unsigned WbufDepth = 4;
  localparam int unsigned PtrWidth  = $clog2(WbufDepth);

  // in-flight write transactions
  localparam int unsigned MaxTx     = 2;
  localparam int unsigned TxIdWidth = $clog2(MaxTx);

  // transfer size codes on the memory port
  localparam int unsigned SizeWidth = 2;
  localparam logic [SizeWidth-1:0] SizeByte = 2'd0;
  localparam logic [SizeWidth-1:0] SizeHalf = 2'd1;
  localparam logic [SizeWidth-1:0] SizeWord = 2'd2;

endpackage

`default_nettype wire
